//--- source/csi2_pkg.sv
package csi2_pkg;

   //////////////////////////////
   // basic field types
   //////////////////////////////

   typedef logic [5:0]  dt_t;
   typedef logic [3:0]  vc_t;
   typedef logic [15:0] wc_t;

   // short packet data types
   localparam dt_t DT_FS = 6'h00;
   localparam dt_t DT_FE = 6'h01;
   localparam dt_t DT_LS = 6'h02;
   localparam dt_t DT_LE = 6'h03;

   // raw8 long packet
   localparam dt_t DT_RAW8_DEFAULT = 6'h2B;

   localparam logic [7:0]  SYNC_BYTE = 8'hB8;
   localparam logic [15:0] CRC_SEED  = 16'hFFFF;
   localparam logic [15:0] CRC_POLY  = 16'h8408;
   // x^16 + x^14 + x^13 + x^11 + 1, right shifting form
   localparam logic [15:0] LFSR_TAPS = 16'hB400;

   typedef enum logic [2:0] {
      PKT_FS,
      PKT_FE,
      PKT_LS,
      PKT_LE,
      PKT_LONG
   } pkt_kind_t;

   typedef struct packed {
      pkt_kind_t kind;
      dt_t       dt;
      vc_t       vc;
      wc_t       wc;
   } pkt_req_t;

   typedef struct packed {
      vc_t         vc;
      dt_t         dt;
      wc_t         wc;
      logic [15:0] lines;
      logic [7:0]  frames;
      logic [15:0] fnum_max;   // 0 keeps frame numbers at zero
      logic        ls_le_en;
      logic [15:0] seed;
   } csi2_cfg_t;

   //////////////////////////////
   // header ecc, crc, lfsr
   //////////////////////////////

   // d = {vc[3:2], byte2, byte1, byte0}
   function automatic logic [7:0] calc_ecc(input logic [25:0] d);
      logic [7:0] e;
      e[0] = ^(d & 26'h1F12CB7);
      e[1] = ^(d & 26'h2F2555B);
      e[2] = ^(d & 26'h3749A6D);
      e[3] = ^(d & 26'h3B8E38E);
      e[4] = ^(d & 26'h3DF03F0);
      e[5] = ^(d & 26'h3EFFC00);
      // top bits carry the extended vc
      e[6] = d[24];
      e[7] = d[25];
      return e;
   endfunction

   // one byte, lsb first
   function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
      logic [15:0] c;
      logic        fb;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         fb = c[0] ^ b[i];
         c = c >> 1;
         if (fb) begin
            c = c ^ CRC_POLY;
         end
      end
      return c;
   endfunction

   // eight shifts per call so each payload byte is fresh
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] r;
      r = (s == '0) ? 16'h0001 : s;
      for (int i = 0; i < 8; i++) begin
         r = r[0] ? ((r >> 1) ^ LFSR_TAPS) : (r >> 1);
      end
      return r;
   endfunction

endpackage

//--- source/lane_pkg.sv
package lane_pkg;

   localparam int MAX_LANES = 4;

   // one byte of the packet stream
   typedef struct packed {
      logic [7:0] data;
      logic       is_sync;
      logic       last;
   } stream_byte_t;

   //////////////////////////////
   // parallel lane output
   //////////////////////////////

   // lanes above NUM_LANES stay zero
   typedef struct packed {
      logic [MAX_LANES-1:0][7:0] lanes;
      logic [MAX_LANES-1:0]      valid;
      logic                      sot;
      logic                      eot;
   } lane_beat_t;

endpackage

//--- source/csi2_cfg_regs.sv
module csi2_cfg_regs import csi2_pkg::*; (
   input  logic        dphy_active,
   input  logic        rst_n_i,
   input  logic        cfg_we_i,
   input  logic [2:0]  cfg_addr_i,
   input  logic [15:0] cfg_wdata_i,
   input  logic        busy_i,
   output csi2_cfg_t   cfg_o,
   output logic        start_o
);

   logic wr_en;

   // configuration is frozen for the whole run
   assign wr_en = cfg_we_i & ~busy_i;

   always_ff @(posedge dphy_active or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg_o.vc       <= '0;
         cfg_o.dt       <= DT_RAW8_DEFAULT;
         cfg_o.wc       <= 16'd16;
         cfg_o.lines    <= 16'd2;
         cfg_o.frames   <= 8'd1;
         cfg_o.fnum_max <= '0;
         cfg_o.ls_le_en <= 1'b0;
         cfg_o.seed     <= 16'hACE1;
         start_o        <= 1'b0;
      end else begin
         start_o <= 1'b0;
         if (wr_en) begin
            case (cfg_addr_i)
               // vc, dt and the ls/le enable share one word
               3'd0: begin
                  cfg_o.vc       <= cfg_wdata_i[3:0];
                  cfg_o.dt       <= cfg_wdata_i[9:4];
                  cfg_o.ls_le_en <= cfg_wdata_i[15];
               end
               3'd1: cfg_o.wc       <= cfg_wdata_i;
               3'd2: cfg_o.lines    <= cfg_wdata_i;
               3'd3: cfg_o.frames   <= cfg_wdata_i[7:0];
               3'd4: cfg_o.fnum_max <= cfg_wdata_i;
               3'd5: cfg_o.seed     <= cfg_wdata_i;
               3'd7: start_o        <= cfg_wdata_i[0];
               default: ;
            endcase
         end
      end
   end

endmodule

//--- source/frame_sequencer.sv
module frame_sequencer import csi2_pkg::*; #(
   parameter int GAP_CYCLES = 8
) (
   input  logic      dphy_active,
   input  logic      rst_n_i,
   input  logic      start_i,
   input  logic      done_i,
   input  csi2_cfg_t cfg_i,
   output logic      req_o,
   output pkt_req_t  pkt_o,
   output logic      busy_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_GAP,
      ST_WAIT
   } seq_state_t;

   localparam logic [15:0] GAP_LOAD = 16'(GAP_CYCLES - 1);

   seq_state_t  state;
   pkt_kind_t   next_kind;
   pkt_kind_t   line_start_kind;
   pkt_req_t    pkt_next;
   logic [15:0] gap_cnt;
   logic [15:0] lnum;
   logic [15:0] fnum;
   logic [7:0]  fcnt;
   logic        run_q;
   logic        last_line;
   logic        last_frame;

   // busy covers the start cycle too, so no write slips in
   assign busy_o = run_q | start_i;

   assign last_line       = (lnum >= cfg_i.lines);
   assign last_frame      = (fcnt >= cfg_i.frames);
   assign line_start_kind = cfg_i.ls_le_en ? PKT_LS : PKT_LONG;

   // fields of the next packet
   always_comb begin
      pkt_next.kind = next_kind;
      pkt_next.vc   = cfg_i.vc;
      case (next_kind)
         PKT_FS: begin
            pkt_next.dt = DT_FS;
            pkt_next.wc = fnum;
         end
         PKT_FE: begin
            pkt_next.dt = DT_FE;
            pkt_next.wc = fnum;
         end
         PKT_LS: begin
            pkt_next.dt = DT_LS;
            pkt_next.wc = lnum;
         end
         PKT_LE: begin
            pkt_next.dt = DT_LE;
            pkt_next.wc = lnum;
         end
         default: begin
            pkt_next.dt = cfg_i.dt;
            pkt_next.wc = cfg_i.wc;
         end
      endcase
   end

   //////////////////////////////
   // frame / line walk
   //////////////////////////////

   always_ff @(posedge dphy_active or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state     <= ST_IDLE;
         next_kind <= PKT_FS;
         gap_cnt   <= '0;
         lnum      <= 16'd1;
         fnum      <= '0;
         fcnt      <= 8'd1;
         run_q     <= 1'b0;
         req_o     <= 1'b0;
         pkt_o     <= '0;
      end else begin
         req_o <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (start_i) begin
                  state     <= ST_GAP;
                  run_q     <= 1'b1;
                  gap_cnt   <= GAP_LOAD;
                  next_kind <= PKT_FS;
                  lnum      <= 16'd1;
                  fcnt      <= 8'd1;
                  fnum      <= (cfg_i.fnum_max != '0) ? 16'd1 : 16'd0;
               end
            end
            ST_GAP: begin
               if (gap_cnt == '0) begin
                  req_o <= 1'b1;
                  pkt_o <= pkt_next;
                  state <= ST_WAIT;
               end else begin
                  gap_cnt <= gap_cnt - 16'd1;
               end
            end
            default: begin
               if (done_i) begin
                  state   <= ST_GAP;
                  gap_cnt <= GAP_LOAD;
                  case (pkt_o.kind)
                     PKT_FS: next_kind <= line_start_kind;
                     PKT_LS: next_kind <= PKT_LONG;
                     PKT_FE: begin
                        // frame number wraps back to 1
                        if (cfg_i.fnum_max != '0) begin
                           fnum <= (fnum >= cfg_i.fnum_max) ? 16'd1 : fnum + 16'd1;
                        end
                        lnum      <= 16'd1;
                        fcnt      <= fcnt + 8'd1;
                        next_kind <= PKT_FS;
                        if (last_frame) begin
                           state <= ST_IDLE;
                           run_q <= 1'b0;
                        end
                     end
                     default: begin
                        // long packet, or LE closing the line
                        if (pkt_o.kind == PKT_LONG && cfg_i.ls_le_en) begin
                           next_kind <= PKT_LE;
                        end else if (last_line) begin
                           next_kind <= PKT_FE;
                        end else begin
                           lnum      <= lnum + 16'd1;
                           next_kind <= line_start_kind;
                        end
                     end
                  endcase
               end
            end
         endcase
      end
   end

endmodule

//--- source/packet_assembler.sv
module packet_assembler import csi2_pkg::*, lane_pkg::*; (
   input  logic         dphy_active,
   input  logic         rst_n_i,
   input  logic         req_i,
   input  pkt_req_t     pkt_i,
   input  logic [15:0]  seed_i,
   output stream_byte_t sbyte_o,
   output logic         sbyte_valid_o,
   output logic         done_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_HDR,
      S_PAY,
      S_CRC
   } asm_state_t;

   asm_state_t       state;
   pkt_req_t         pkt_q;
   logic [3:0][7:0]  hdr;
   logic [1:0]       idx;
   logic [15:0]      cnt;
   logic [15:0]      crc_q;
   logic [15:0]      lfsr_q;
   logic             is_long;

   assign is_long = (pkt_q.kind == PKT_LONG);

   // packet header, ecc last
   assign hdr[0] = {pkt_q.vc[1:0], pkt_q.dt};
   assign hdr[1] = pkt_q.wc[7:0];
   assign hdr[2] = pkt_q.wc[15:8];
   assign hdr[3] = calc_ecc({pkt_q.vc[3:2], hdr[2], hdr[1], hdr[0]});

   //////////////////////////////
   // payload and checksum
   //////////////////////////////

   always_ff @(posedge dphy_active) begin
      if (req_i) begin
         pkt_q <= pkt_i;
         crc_q <= CRC_SEED;
         // new payload sequence every frame
         if (pkt_i.kind == PKT_FS) begin
            lfsr_q <= seed_i;
         end
      end else if (state == S_PAY) begin
         crc_q  <= crc16_byte(crc_q, lfsr_q[7:0]);
         lfsr_q <= lfsr_next(lfsr_q);
      end
   end

   //////////////////////////////
   // byte sequencing
   //////////////////////////////

   always_ff @(posedge dphy_active or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state         <= S_IDLE;
         idx           <= '0;
         cnt           <= '0;
         sbyte_o       <= '0;
         sbyte_valid_o <= 1'b0;
         done_o        <= 1'b0;
      end else begin
         done_o <= sbyte_valid_o & sbyte_o.last;
         case (state)
            S_IDLE: begin
               sbyte_valid_o <= req_i;
               if (req_i) begin
                  sbyte_o.data    <= SYNC_BYTE;
                  sbyte_o.is_sync <= 1'b1;
                  sbyte_o.last    <= 1'b0;
                  idx             <= '0;
                  state           <= S_HDR;
               end
            end
            S_HDR: begin
               sbyte_o.data    <= hdr[idx];
               sbyte_o.is_sync <= 1'b0;
               sbyte_o.last    <= (idx == 2'd3) & ~is_long;
               idx             <= idx + 2'd1;
               if (idx == 2'd3) begin
                  cnt <= '0;
                  if (!is_long) begin
                     state <= S_IDLE;
                  end else if (pkt_q.wc == '0) begin
                     state <= S_CRC;
                  end else begin
                     state <= S_PAY;
                  end
               end
            end
            S_PAY: begin
               sbyte_o.data <= lfsr_q[7:0];
               sbyte_o.last <= 1'b0;
               cnt          <= cnt + 16'd1;
               if (cnt == pkt_q.wc - 16'd1) begin
                  idx   <= '0;
                  state <= S_CRC;
               end
            end
            default: begin
               // low byte then high byte
               if (idx == '0) begin
                  sbyte_o.data <= crc_q[7:0];
                  sbyte_o.last <= 1'b0;
                  idx          <= 2'd1;
               end else begin
                  sbyte_o.data <= crc_q[15:8];
                  sbyte_o.last <= 1'b1;
                  state        <= S_IDLE;
               end
            end
         endcase
      end
   end

endmodule

//--- source/lane_distributor.sv
module lane_distributor import lane_pkg::*; #(
   parameter int NUM_LANES = 4
) (
   input  logic         dphy_active,
   input  logic         rst_n_i,
   input  logic         sbyte_valid_i,
   input  stream_byte_t sbyte_i,
   output lane_beat_t   beat_o,
   output logic         beat_valid_o
);

   localparam logic [MAX_LANES-1:0] USED_MASK = MAX_LANES'((1 << NUM_LANES) - 1);

   logic [1:0]                fill_q;
   logic [MAX_LANES-1:0][7:0] lanes_q;
   logic [MAX_LANES-1:0][7:0] lanes_mrg;
   logic [MAX_LANES-1:0][7:0] sync_lanes;
   logic [MAX_LANES-1:0]      mask_mrg;
   logic                      beat_full;

   // held lanes plus the incoming byte
   always_comb begin
      for (int i = 0; i < MAX_LANES; i++) begin
         if (i < fill_q) begin
            lanes_mrg[i] = lanes_q[i];
         end else if (i == fill_q) begin
            lanes_mrg[i] = sbyte_i.data;
         end else begin
            lanes_mrg[i] = 8'h00;
         end
         mask_mrg[i]   = (i <= fill_q);
         sync_lanes[i] = USED_MASK[i] ? sbyte_i.data : 8'h00;
      end
   end

   assign beat_full = (fill_q == 2'(NUM_LANES - 1)) | sbyte_i.last;

   always_ff @(posedge dphy_active) begin
      if (sbyte_valid_i && !sbyte_i.is_sync) begin
         lanes_q[fill_q] <= sbyte_i.data;
      end
   end

   always_ff @(posedge dphy_active or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fill_q       <= '0;
         beat_o       <= '0;
         beat_valid_o <= 1'b0;
      end else begin
         beat_valid_o <= 1'b0;
         if (sbyte_valid_i) begin
            if (sbyte_i.is_sync) begin
               // sync goes out alone on every lane
               beat_o.lanes <= sync_lanes;
               beat_o.valid <= USED_MASK;
               beat_o.sot   <= 1'b1;
               beat_o.eot   <= 1'b0;
               beat_valid_o <= 1'b1;
               fill_q       <= '0;
            end else if (beat_full) begin
               beat_o.lanes <= lanes_mrg;
               beat_o.valid <= mask_mrg;
               beat_o.sot   <= 1'b0;
               beat_o.eot   <= sbyte_i.last;
               beat_valid_o <= 1'b1;
               fill_q       <= '0;
            end else begin
               fill_q <= fill_q + 2'd1;
            end
         end
      end
   end

endmodule

//--- source/csi2_tx_top.sv
module csi2_tx_top import csi2_pkg::*, lane_pkg::*; #(
   parameter int NUM_LANES  = 4,
   parameter int GAP_CYCLES = 8
) (
   input  logic        dphy_active,
   input  logic        rst_n_i,
   input  logic        cfg_we_i,
   input  logic [2:0]  cfg_addr_i,
   input  logic [15:0] cfg_wdata_i,
   output lane_beat_t  beat_o,
   output logic        beat_valid_o,
   output logic        busy_o
);

   csi2_cfg_t    cfg;
   pkt_req_t     pkt;
   stream_byte_t sbyte;
   logic         start;
   logic         req;
   logic         done;
   logic         sbyte_valid;

   csi2_cfg_regs csi2_cfg_regs_inst (
      .dphy_active (dphy_active),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .busy_i      (busy_o),
      .cfg_o       (cfg),
      .start_o     (start)
   );

   frame_sequencer #(
      .GAP_CYCLES (GAP_CYCLES)
   ) frame_sequencer_inst (
      .dphy_active (dphy_active),
      .rst_n_i     (rst_n_i),
      .start_i     (start),
      .done_i      (done),
      .cfg_i       (cfg),
      .req_o       (req),
      .pkt_o       (pkt),
      .busy_o      (busy_o)
   );

   packet_assembler packet_assembler_inst (
      .dphy_active   (dphy_active),
      .rst_n_i       (rst_n_i),
      .req_i         (req),
      .pkt_i         (pkt),
      .seed_i        (cfg.seed),
      .sbyte_o       (sbyte),
      .sbyte_valid_o (sbyte_valid),
      .done_o        (done)
   );

   lane_distributor #(
      .NUM_LANES (NUM_LANES)
   ) lane_distributor_inst (
      .dphy_active   (dphy_active),
      .rst_n_i       (rst_n_i),
      .sbyte_valid_i (sbyte_valid),
      .sbyte_i       (sbyte),
      .beat_o        (beat_o),
      .beat_valid_o  (beat_valid_o)
   );

endmodule

//--- tests/csi2_tx_assertions.sv
module csi2_tx_assertions import csi2_pkg::*, lane_pkg::*; (
   input  logic        dphy_active,
   input  logic        rst_n_i,
   input  logic        cfg_we_i,
   input  logic [2:0]  cfg_addr_i,
   input  logic [15:0] cfg_wdata_i,
   input  lane_beat_t  beat_o,
   input  logic        beat_valid_o,
   input  logic        busy_o
);

   bit err_flag = 1'b0;

   // configuration as seen from the register writes
   logic [3:0]  m_vc;
   logic [5:0]  m_dt;
   logic [15:0] m_wc;
   logic [15:0] m_lines;
   logic [7:0]  m_frames;
   logic [15:0] m_fnum_max;
   logic        m_ls_le;
   logic        cfg_wr;

   // expected packet order
   logic        started;
   pkt_kind_t   exp_kind;
   logic [15:0] exp_line;
   logic [15:0] exp_fnum;
   logic [7:0]  frames_seen;
   logic [5:0]  exp_dt;
   logic [15:0] exp_wc;
   logic [7:0]  ecc_exp;

   // current packet body
   logic        hdr_phase;
   logic        long_q;
   logic [15:0] wc_q;
   logic [15:0] k_q;
   logic [15:0] crc_q;
   logic [15:0] rx_q;
   logic [15:0] k_now;
   logic [15:0] crc_now;
   logic [15:0] rx_now;
   logic [15:0] n_bytes;
   logic [3:0]  mask_exp;

   //////////////////////////////
   // reference ecc and crc
   //////////////////////////////

   // parity sets as listed in the csi-2 header ecc definition
   function automatic logic [7:0] hdr_ecc(input logic [25:0] d);
      logic [7:0] p;
      p[0] = ^{d[2:0], d[5:4], d[7], d[11:10], d[13], d[16], d[24:20]};
      p[1] = ^{d[1:0], d[4:3], d[6], d[8], d[10], d[12], d[14], d[17], d[23:20], d[25]};
      p[2] = ^{d[0], d[3:2], d[6:5], d[9], d[12:11], d[15], d[18], d[22:20], d[25:24]};
      p[3] = ^{d[3:1], d[9:7], d[15:13], d[21:19], d[25:23]};
      p[4] = ^{d[9:4], d[20:16], d[25:22]};
      p[5] = ^{d[19:10], d[25:21]};
      p[7:6] = d[25:24];
      return p;
   endfunction

   // reflected crc-16, poly 0x8408, data lsb first
   function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [7:0] b);
      logic [15:0] r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         if (r[0] ^ b[i]) begin
            r = (r >> 1) ^ 16'h8408;
         end else begin
            r = r >> 1;
         end
      end
      return r;
   endfunction

   assign cfg_wr  = cfg_we_i & ~busy_o;
   assign ecc_exp = hdr_ecc({m_vc[3:2], beat_o.lanes[2], beat_o.lanes[1], beat_o.lanes[0]});
   assign n_bytes = hdr_phase ? 16'd4 : wc_q + 16'd6;

   always_comb begin
      case (n_bytes[1:0])
         2'd1:    mask_exp = 4'b0001;
         2'd2:    mask_exp = 4'b0011;
         2'd3:    mask_exp = 4'b0111;
         default: mask_exp = 4'b1111;
      endcase
   end

   always_comb begin
      case (exp_kind)
         PKT_FS: begin
            exp_dt = DT_FS;
            exp_wc = exp_fnum;
         end
         PKT_FE: begin
            exp_dt = DT_FE;
            exp_wc = exp_fnum;
         end
         PKT_LS: begin
            exp_dt = DT_LS;
            exp_wc = exp_line;
         end
         PKT_LE: begin
            exp_dt = DT_LE;
            exp_wc = exp_line;
         end
         default: begin
            exp_dt = m_dt;
            exp_wc = m_wc;
         end
      endcase
   end

   // payload bytes feed the crc and the two after them are the received crc
   always_comb begin
      k_now   = k_q;
      crc_now = crc_q;
      rx_now  = rx_q;
      for (int i = 0; i < MAX_LANES; i++) begin
         if (beat_o.valid[i]) begin
            if (k_now < wc_q) begin
               crc_now = crc_step(crc_now, beat_o.lanes[i]);
            end else if (k_now == wc_q) begin
               rx_now[7:0] = beat_o.lanes[i];
            end else begin
               rx_now[15:8] = beat_o.lanes[i];
            end
            k_now = k_now + 16'd1;
         end
      end
   end

   //////////////////////////////
   // reference state
   //////////////////////////////

   always_ff @(posedge dphy_active or negedge rst_n_i) begin
      if (!rst_n_i) begin
         m_vc        <= '0;
         m_dt        <= DT_RAW8_DEFAULT;
         m_wc        <= 16'd16;
         m_lines     <= 16'd2;
         m_frames    <= 8'd1;
         m_fnum_max  <= '0;
         m_ls_le     <= 1'b0;
         started     <= 1'b0;
         exp_kind    <= PKT_FS;
         exp_line    <= 16'd1;
         exp_fnum    <= '0;
         frames_seen <= '0;
         hdr_phase   <= 1'b0;
         long_q      <= 1'b0;
         wc_q        <= '0;
         k_q         <= '0;
         crc_q       <= 16'hFFFF;
         rx_q        <= '0;
      end else begin
         if (cfg_wr) begin
            case (cfg_addr_i)
               3'd0: begin
                  m_vc    <= cfg_wdata_i[3:0];
                  m_dt    <= cfg_wdata_i[9:4];
                  m_ls_le <= cfg_wdata_i[15];
               end
               3'd1: m_wc       <= cfg_wdata_i;
               3'd2: m_lines    <= cfg_wdata_i;
               3'd3: m_frames   <= cfg_wdata_i[7:0];
               3'd4: m_fnum_max <= cfg_wdata_i;
               3'd7: begin
                  if (cfg_wdata_i[0]) begin
                     started     <= 1'b1;
                     exp_kind    <= PKT_FS;
                     exp_line    <= 16'd1;
                     exp_fnum    <= (m_fnum_max != '0) ? 16'd1 : 16'd0;
                     frames_seen <= '0;
                  end
               end
               default: ;
            endcase
         end
         if (beat_valid_o) begin
            if (beat_o.sot) begin
               hdr_phase <= 1'b1;
            end else if (hdr_phase) begin
               hdr_phase <= 1'b0;
               long_q    <= (exp_kind == PKT_LONG);
               wc_q      <= exp_wc;
               k_q       <= '0;
               crc_q     <= 16'hFFFF;
               case (exp_kind)
                  PKT_FS: exp_kind <= m_ls_le ? PKT_LS : PKT_LONG;
                  PKT_LS: exp_kind <= PKT_LONG;
                  PKT_FE: begin
                     exp_line    <= 16'd1;
                     frames_seen <= frames_seen + 8'd1;
                     exp_kind    <= PKT_FS;
                     if (m_fnum_max != '0) begin
                        exp_fnum <= (exp_fnum >= m_fnum_max) ? 16'd1 : exp_fnum + 16'd1;
                     end
                  end
                  default: begin
                     if (exp_kind == PKT_LONG && m_ls_le) begin
                        exp_kind <= PKT_LE;
                     end else if (exp_line >= m_lines) begin
                        exp_kind <= PKT_FE;
                     end else begin
                        exp_line <= exp_line + 16'd1;
                        exp_kind <= m_ls_le ? PKT_LS : PKT_LONG;
                     end
                  end
               endcase
            end else begin
               k_q   <= k_now;
               crc_q <= crc_now;
               rx_q  <= rx_now;
            end
         end
      end
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   a_idle: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      !started |-> !beat_valid_o)
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: beat_valid_o expected 0 actual 1 before start", $time);
      end

   a_sync: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      beat_valid_o && beat_o.sot |->
         beat_o.lanes == {MAX_LANES{SYNC_BYTE}} && beat_o.valid == 4'hF)
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: beat_o.lanes/valid expected %h/f actual %h/%h",
            $time, {MAX_LANES{SYNC_BYTE}}, $sampled(beat_o.lanes), $sampled(beat_o.valid));
      end

   a_hdr_ecc: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      beat_valid_o && hdr_phase |-> beat_o.lanes[3] == ecc_exp && beat_o.valid == 4'hF)
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: beat_o.lanes[3]/valid expected %h/f actual %h/%h",
            $time, $sampled(ecc_exp), $sampled(beat_o.lanes[3]), $sampled(beat_o.valid));
      end

   a_hdr_vc: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      beat_valid_o && hdr_phase |-> beat_o.lanes[0][7:6] == m_vc[1:0])
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: beat_o.lanes[0][7:6] expected %h actual %h", $time,
            $sampled(m_vc[1:0]), $sampled(beat_o.lanes[0][7:6]));
      end

   a_hdr_dt: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      beat_valid_o && hdr_phase |-> beat_o.lanes[0][5:0] == exp_dt)
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: beat_o.lanes[0][5:0] expected %h actual %h", $time,
            $sampled(exp_dt), $sampled(beat_o.lanes[0][5:0]));
      end

   a_hdr_wc: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      beat_valid_o && hdr_phase |-> {beat_o.lanes[2], beat_o.lanes[1]} == exp_wc)
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: beat_o.lanes[2:1] expected %0d actual %0d", $time,
            $sampled(exp_wc), $sampled({beat_o.lanes[2], beat_o.lanes[1]}));
      end

   a_crc: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      beat_valid_o && beat_o.eot && long_q && !hdr_phase |-> rx_now == crc_now)
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: beat_o.lanes crc bytes expected %h actual %h", $time,
            $sampled(crc_now), $sampled(rx_now));
      end

   a_eot_mask: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      beat_valid_o && beat_o.eot |-> beat_o.valid == mask_exp)
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: beat_o.valid on eot expected %h actual %h", $time,
            $sampled(mask_exp), $sampled(beat_o.valid));
      end

   a_frames: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      $fell(busy_o) |-> frames_seen == m_frames)
      else begin
         err_flag = 1'b1;
         $error("CHECK FAILED at %0t: frames_seen when busy_o fell expected %0d actual %0d",
            $time, $sampled(m_frames), $sampled(frames_seen));
      end

endmodule

bind csi2_tx_top csi2_tx_assertions csi2_tx_assertions_inst (
   .dphy_active  (dphy_active),
   .rst_n_i      (rst_n_i),
   .cfg_we_i     (cfg_we_i),
   .cfg_addr_i   (cfg_addr_i),
   .cfg_wdata_i  (cfg_wdata_i),
   .beat_o       (beat_o),
   .beat_valid_o (beat_valid_o),
   .busy_o       (busy_o)
);

//--- tests/csi2_tx_tb.sv
module csi2_tx_tb import lane_pkg::*; ();

   localparam int NUM_LANES  = 4;
   localparam int GAP_CYCLES = 8;
   localparam int CLK_HALF   = 20;
   localparam int DRV_DLY    = 2;
   localparam int NUM_RUNS   = 3;

   logic        dphy_active;
   logic        rst_n_i;
   logic        cfg_we_i;
   logic [2:0]  cfg_addr_i;
   logic [15:0] cfg_wdata_i;
   lane_beat_t  beat_o;
   logic        beat_valid_o;
   logic        busy_o;
   logic        check_err;
   longint      limit_cycles = 64;
   longint      cycle_cnt;

   csi2_tx_top #(
      .NUM_LANES  (NUM_LANES),
      .GAP_CYCLES (GAP_CYCLES)
   ) csi2_tx_top_inst (
      .dphy_active  (dphy_active),
      .rst_n_i      (rst_n_i),
      .cfg_we_i     (cfg_we_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_wdata_i  (cfg_wdata_i),
      .beat_o       (beat_o),
      .beat_valid_o (beat_valid_o),
      .busy_o       (busy_o)
   );

   // raised by the bound checker
   assign check_err = csi2_tx_top_inst.csi2_tx_assertions_inst.err_flag;

   initial dphy_active = 1'b0;
   always #(CLK_HALF) dphy_active = ~dphy_active;

   //////////////////////////////
   // drive helpers
   //////////////////////////////

   task automatic step_cycle();
      @(posedge dphy_active);
      #(DRV_DLY);
   endtask

   task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
      step_cycle();
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      step_cycle();
      cfg_we_i = 1'b0;
   endtask

   // one complete transmit run with fresh random settings
   task automatic run_frames(input int run);
      logic [15:0] wc;
      logic [15:0] lines;
      logic [5:0]  dt;
      logic [3:0]  vc;
      logic        ls_le;
      // wc residues 3, 0, 1 give short final beats of 1, 2 and 3 lanes
      wc    = 16'(4 * ($urandom % 10) + (run + 2) % 4 + 1);
      lines = 16'(2 + $urandom % 2);
      dt    = 6'h28 + 6'($urandom % 8);
      vc    = 4'($urandom % 16);
      ls_le = (run % 2 == 0);
      limit_cycles = limit_cycles + 3 * (2 * int'(lines) * (int'(wc) + 40) + 200);
      $display("run %0d: wc %0d lines %0d dt %h vc %h ls_le %0b", run, wc, lines, dt, vc, ls_le);
      write_reg(3'd0, {ls_le, 5'd0, dt, vc});
      write_reg(3'd1, wc);
      write_reg(3'd2, lines);
      write_reg(3'd3, 16'd2);
      write_reg(3'd4, 16'd2);
      write_reg(3'd5, 16'($urandom));
      write_reg(3'd7, 16'd1);
      while (!busy_o) begin
         step_cycle();
      end
      // writes during a run leave its settings alone
      if (run == 1) begin
         write_reg(3'd1, wc + 16'd5);
         write_reg(3'd0, {~ls_le, 5'd0, dt ^ 6'h01, vc});
      end
      while (busy_o) begin
         step_cycle();
      end
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      rst_n_i     = 1'b0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = '0;
      cfg_wdata_i = '0;
      void'($urandom(32'ha826_995b));
      repeat (10) @(posedge dphy_active);
      #(DRV_DLY);
      rst_n_i = 1'b1;
      // quiet output until the first start
      repeat (6) step_cycle();
      for (int run = 0; run < NUM_RUNS; run++) begin
         run_frames(run);
         repeat (4) step_cycle();
      end
      if (check_err) begin
         $display("test failed");
         $fatal(1, "a protocol check reported an error");
      end else begin
         $display("test passed");
         $finish;
      end
   end

   initial begin : error_monitor
      wait (check_err);
      $display("test failed");
      $fatal(1, "stopping at the first reported check error");
   end

   // limit grows with each run's bound
   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < limit_cycles) begin
         @(posedge dphy_active);
         cycle_cnt = cycle_cnt + 1;
      end
      $display("test failed");
      $fatal(1, "timeout, the runs did not finish within %0d cycles", limit_cycles);
   end

endmodule

//--- vlog.f
source/csi2_pkg.sv
source/lane_pkg.sv
source/csi2_cfg_regs.sv
source/frame_sequencer.sv
source/packet_assembler.sv
source/lane_distributor.sv
source/csi2_tx_top.sv
tests/csi2_tx_assertions.sv
tests/csi2_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the csi2 transmitter testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module csi2_tx_tb \
   -f vlog.f -o csi2_tx_sim || { echo "build failed"; exit 1; }
./obj_dir/csi2_tx_sim +verilator+error+limit+10 > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0
